// File: all.f
common/ipod_pkg.sv
rtl/speed_control.sv
rtl/sample_tick_gen.sv
playback/playback_ctrl.sv
playback/flash_reader.sv
rtl/hex_display.sv
rtl/ipod_player_top.sv
verif/ipod_player_sva.sv
verif/tb_ipod_player.sv

// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
TOP        = tb_ipod_player
FILELIST   = all.f
OBJ_DIR    = obj_dir
PASS_MSG   = sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_ipod_player.sv
`timescale 1ns/1ps

module tb_ipod_player;

  localparam ipod_pkg::div_t  T_DIV_DEFAULT = 24'd40;
  localparam ipod_pkg::div_t  T_DIV_STEP    = 24'd4;
  localparam ipod_pkg::div_t  T_DIV_MIN     = 24'd24;
  localparam ipod_pkg::div_t  T_DIV_MAX     = 24'd60;
  localparam int              T_REPEAT      = 16;
  localparam ipod_pkg::addr_t T_ADDR_LAST   = 23'd15;
  localparam int              T_REFRESH     = 32;
  localparam int              NUM_WORDS     = 16;
  localparam logic [31:0]     LCG_SEED      = 32'ha28f;

  // Standard active low digits in gfedcba order
  localparam ipod_pkg::seg_t SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic                  CLK_50M;
  logic                  rst_n;
  logic [2:0]            key_n;
  ipod_pkg::ascii_t      kbd_ascii;
  logic                  kbd_valid;
  ipod_pkg::flash_word_t flash_readdata;
  logic                  flash_readdatavalid;
  logic                  flash_read;
  ipod_pkg::addr_t       flash_address;
  ipod_pkg::sample_t     audio_sample;
  logic                  audio_valid;
  ipod_pkg::seg_t        hex0;
  ipod_pkg::seg_t        hex1;
  ipod_pkg::seg_t        hex2;
  ipod_pkg::seg_t        hex3;
  ipod_pkg::seg_t        hex4;
  ipod_pkg::seg_t        hex5;
  logic                  led_playing;
  logic                  led_forward;

  ipod_pkg::flash_word_t flash_mem [0:NUM_WORDS-1];
  ipod_pkg::sample_t     got_q [$];   // Samples seen on audio_valid
  int                    got_cyc [$]; // Cycle of each sample
  int                    cyc_cnt = 0;
  int                    err_cnt = 0;
  int                    check_cnt = 0;
  int                    flash_err_cnt = 0;
  bit                    timed_out = 1'b0;
  bit                    rand_lat = 1'b0;
  int                    lat_left = 0;
  logic [31:0]           lat_state = LCG_SEED;
  ipod_pkg::addr_t       rd_addr;
  ipod_pkg::div_t        cur_div = T_DIV_DEFAULT;
  ipod_pkg::addr_t       m_addr = '0;  // Reference model position
  logic                  m_fwd = 1'b1;
  logic                  m_idx = 1'b0;

  ipod_player_top #(
    .DIV_DEFAULT      (T_DIV_DEFAULT),
    .DIV_STEP         (T_DIV_STEP),
    .DIV_MIN          (T_DIV_MIN),
    .DIV_MAX          (T_DIV_MAX),
    .KEY_REPEAT_CYCLES(T_REPEAT),
    .ADDR_LAST        (T_ADDR_LAST),
    .REFRESH_CYCLES   (T_REFRESH)
  ) i_dut (
    .CLK_50M            (CLK_50M),
    .rst_n              (rst_n),
    .key_n              (key_n),
    .kbd_ascii          (kbd_ascii),
    .kbd_valid          (kbd_valid),
    .flash_readdata     (flash_readdata),
    .flash_readdatavalid(flash_readdatavalid),
    .flash_read         (flash_read),
    .flash_address      (flash_address),
    .audio_sample       (audio_sample),
    .audio_valid        (audio_valid),
    .hex0               (hex0),
    .hex1               (hex1),
    .hex2               (hex2),
    .hex3               (hex3),
    .hex4               (hex4),
    .hex5               (hex5),
    .led_playing        (led_playing),
    .led_forward        (led_forward)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // ==================================================
  // Sample monitor and flash model
  // ==================================================
  always @(negedge CLK_50M)
  begin
    cyc_cnt = cyc_cnt + 1;
    if (rst_n && audio_valid)
    begin
      got_q.push_back(audio_sample);
      got_cyc.push_back(cyc_cnt);
    end
  end

  always @(negedge CLK_50M)
  begin
    flash_readdatavalid = 1'b0;
    if (lat_left > 0)
    begin
      lat_left = lat_left - 1;
      if (lat_left == 0)
      begin
        flash_readdata      = flash_mem[rd_addr[3:0]];
        flash_readdatavalid = 1'b1;
      end
    end
    if (rst_n && flash_read)
    begin
      if (lat_left > 0 || flash_address > T_ADDR_LAST)
      begin
        flash_err_cnt = flash_err_cnt + 1;
        $display("Flash read at %0t overlaps a pending read or is out of range", $time);
      end
      rd_addr = flash_address;
      if (rand_lat)
      begin
        lat_state = lcg_next(lat_state);
        lat_left  = int'(lat_state[18:16]) + 1;  // 1 to 8 cycles
      end
      else
        lat_left = 1;
    end
  end

  // ==================================================
  // Checking helpers
  // ==================================================
  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_cnt = check_cnt + 1;
    if (got !== exp)
    begin
      err_cnt = err_cnt + 1;
      $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    err_cnt   = err_cnt + 1;
    timed_out = 1'b1;
    $display("Timed out at %0t ns while waiting for %s", $time, what);
  endtask

  function automatic logic [3:0] seg_to_nib(input ipod_pkg::seg_t s);
    logic [3:0] nib;
    nib = 4'bxxxx;
    for (int i = 0; i < 16; i++)
    begin
      if (s == SEG_TABLE[i])
        nib = 4'(i);
    end
    return nib;
  endfunction

  function automatic ipod_pkg::div_t displayed();
    return {seg_to_nib(hex5), seg_to_nib(hex4), seg_to_nib(hex3),
            seg_to_nib(hex2), seg_to_nib(hex1), seg_to_nib(hex0)};
  endfunction

  task automatic build_flash_table();
    logic [31:0] s;
    s = LCG_SEED;
    for (int k = 0; k < NUM_WORDS; k++)
    begin
      s            = lcg_next(s);
      flash_mem[k] = s;
    end
  endtask

  // Next sample by the direction's half order
  task automatic next_expected(output ipod_pkg::sample_t s);
    ipod_pkg::flash_word_t w;
    logic                  upper;
    w     = flash_mem[m_addr[3:0]];
    upper = m_fwd ? m_idx : ~m_idx;
    s     = upper ? w[31:24] : w[15:8];
    if (m_idx)
    begin
      m_idx = 1'b0;
      if (m_fwd)
        m_addr = (m_addr == T_ADDR_LAST) ? '0 : m_addr + 1'b1;
      else
        m_addr = (m_addr == '0) ? T_ADDR_LAST : m_addr - 1'b1;
    end
    else
      m_idx = 1'b1;
  endtask

  task automatic restart_model(input logic fwd);
    m_fwd  = fwd;
    m_addr = fwd ? '0 : T_ADDR_LAST;
    m_idx  = 1'b0;
  endtask

  task automatic send_key(input ipod_pkg::ascii_t ch);
    @(negedge CLK_50M);
    kbd_ascii = ch;
    kbd_valid = 1'b1;
    @(negedge CLK_50M);
    kbd_valid = 1'b0;
    @(negedge CLK_50M);
  endtask

  task automatic hold_key(input int idx, input int cycles);
    @(negedge CLK_50M);
    key_n[idx] = 1'b0;
    repeat (cycles) @(negedge CLK_50M);
    key_n[idx] = 1'b1;
  endtask

  task automatic wait_samples(input int n, output bit ok);
    int waited;
    int limit;
    waited = 0;
    limit  = n * (int'(cur_div) + 16) + 100;
    while (got_q.size() < n && waited < limit)
    begin
      @(negedge CLK_50M);
      waited++;
    end
    ok = (got_q.size() >= n);
    if (!ok)
      report_timeout($sformatf("%0d audio samples", n));
  endtask

  // Period 0 skips the spacing check
  task automatic check_samples(input int n, input int period, output bit ok);
    ipod_pkg::sample_t got;
    ipod_pkg::sample_t exp;
    int                c;
    int                prev_c;
    wait_samples(n, ok);
    prev_c = 0;
    for (int i = 0; ok && i < n; i++)
    begin
      got = got_q.pop_front();
      c   = got_cyc.pop_front();
      next_expected(exp);
      check_eq(32'(got), 32'(exp), "audio sample");
      if (period > 0 && i > 0)
        check_eq(32'(c - prev_c), 32'(period), "sample spacing");
      prev_c = c;
    end
  endtask

  task automatic drain_samples();
    ipod_pkg::sample_t exp;
    while (got_q.size() > 0)
    begin
      next_expected(exp);
      check_eq(32'(got_q.pop_front()), 32'(exp), "audio sample");
      void'(got_cyc.pop_front());
    end
  endtask

  task automatic settle_display(input ipod_pkg::div_t exp, output bit ok);
    int waited;
    waited = 0;
    while (displayed() !== exp && waited < T_REFRESH + T_REPEAT + 8)
    begin
      @(negedge CLK_50M);
      waited++;
    end
    ok = (displayed() === exp);
    if (!ok)
      report_timeout($sformatf("display to show 0x%0h", exp));
    repeat (T_REFRESH + T_REPEAT) @(negedge CLK_50M);  // Value must stay put
    check_eq(32'(displayed()), 32'(exp), "hex display");
    cur_div = exp;
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic idle_after_reset();
    repeat (200)
    begin
      @(negedge CLK_50M);
      if (audio_valid || flash_read)
        check_eq(32'({audio_valid, flash_read}), 32'd0, "strobes idle after reset");
    end
    check_eq(32'(displayed()), 32'(T_DIV_DEFAULT), "hex display after reset");
    check_eq(32'(led_playing), 32'd0, "led_playing after reset");
    check_eq(32'(led_forward), 32'd1, "led_forward after reset");
  endtask

  task automatic forward_play();
    bit ok;
    send_key(ipod_pkg::CMD_PLAY);
    check_eq(32'(led_playing), 32'd1, "led_playing after E");
    check_samples(40, int'(cur_div), ok);  // Covers the wrap at word 15
  endtask

  task automatic pause_resume();
    bit ok;
    int stray;
    stray = 0;
    send_key(ipod_pkg::CMD_PAUSE);
    check_eq(32'(led_playing), 32'd0, "led_playing after D");
    repeat (10 * int'(cur_div))
    begin
      @(negedge CLK_50M);
      if (audio_valid)
        stray++;
    end
    check_eq(32'(stray), 32'd0, "samples during pause");
    send_key(ipod_pkg::CMD_PLAY);
    check_samples(8, 0, ok);
  endtask

  task automatic reverse_restart();
    bit ok;
    send_key(ipod_pkg::CMD_PAUSE);
    drain_samples();
    send_key(ipod_pkg::CMD_BACK);
    check_eq(32'(led_forward), 32'd0, "led_forward after B");
    send_key(ipod_pkg::CMD_RESTART);
    restart_model(1'b0);
    send_key(ipod_pkg::CMD_PLAY);
    check_samples(12, 0, ok);
    if (!ok)
      return;
    send_key(8'h58);  // 'X'
    send_key(8'h65);  // Lower case 'e'
    send_key(8'h00);
    check_eq(32'({led_playing, led_forward}), 32'b10, "flags after other characters");
    check_samples(6, 0, ok);
    if (!ok)
      return;
    send_key(ipod_pkg::CMD_PAUSE);
    drain_samples();
    send_key(ipod_pkg::CMD_FWD);
    send_key(ipod_pkg::CMD_RESTART);
    restart_model(1'b1);
    send_key(ipod_pkg::CMD_PLAY);
    check_samples(6, 0, ok);
    send_key(ipod_pkg::CMD_PAUSE);
    drain_samples();
  endtask

  task automatic speed_keys();
    bit ok;
    hold_key(0, 3 * T_REPEAT);  // Up key for three windows
    settle_display(T_DIV_DEFAULT - 3 * T_DIV_STEP, ok);
    if (!ok)
      return;
    hold_key(0, 4 * T_REPEAT);
    settle_display(T_DIV_MIN, ok);
    if (!ok)
      return;
    hold_key(1, 12 * T_REPEAT);  // Down key
    settle_display(T_DIV_MAX, ok);
    if (!ok)
      return;
    hold_key(2, 4);
    settle_display(T_DIV_DEFAULT, ok);
  endtask

  task automatic random_latency();
    bit ok;
    hold_key(0, 5 * T_REPEAT);
    settle_display(T_DIV_MIN, ok);
    if (!ok)
      return;
    rand_lat = 1'b1;
    send_key(ipod_pkg::CMD_PLAY);
    check_samples(20, 0, ok);
    if (!ok)
      return;
    send_key(ipod_pkg::CMD_RESTART);  // Restart while playing may drop a pending word
    drain_samples();
    restart_model(1'b1);
    check_samples(30, 0, ok);
    send_key(ipod_pkg::CMD_PAUSE);
    drain_samples();
  endtask

  initial
  begin
    rst_n               = 1'b0;
    key_n               = 3'b111;
    kbd_ascii           = '0;
    kbd_valid           = 1'b0;
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
    build_flash_table();
    repeat (16) @(negedge CLK_50M);
    rst_n = 1'b1;

    idle_after_reset();
    if (!timed_out)
      forward_play();
    if (!timed_out)
      pause_resume();
    if (!timed_out)
      reverse_restart();
    if (!timed_out)
      speed_keys();
    if (!timed_out)
      random_latency();
    check_eq(32'(flash_err_cnt), 32'd0, "flash protocol errors");
    check_eq(32'(i_dut.i_sva.fail_cnt), 32'd0, "assertion failures");

    $display("Done: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// File: verif/ipod_player_sva.sv
`timescale 1ns/1ps

module ipod_player_sva (
  input logic CLK_50M,
  input logic rst_n,
  input logic sample_tick,
  input logic audio_valid,
  input logic word_req_pulse,
  input logic word_rsp_valid,
  input logic flash_read,
  input logic flash_readdatavalid
);

  logic word_busy;     // Word request in flight
  logic read_busy;     // Flash read in flight
  int   fail_cnt = 0;  // Failed assertions so far

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      word_busy <= 1'b0;
      read_busy <= 1'b0;
    end
    else
    begin
      if (word_req_pulse)
        word_busy <= 1'b1;
      else if (word_rsp_valid)
        word_busy <= 1'b0;
      if (flash_read)
        read_busy <= 1'b1;
      else if (flash_readdatavalid)
        read_busy <= 1'b0;
    end
  end

  // ==================================================
  // Strobe and handshake properties
  // ==================================================
  a_valid_on_tick: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    audio_valid |-> sample_tick ##1 !audio_valid)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("audio_valid without sample_tick or longer than one cycle");
  end

  a_one_word_req: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    word_req_pulse |-> !word_busy)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("word request while a word is outstanding");
  end

  a_one_flash_read: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_read |-> !read_busy)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("flash_read while waiting for read data");
  end

endmodule

bind ipod_player_top ipod_player_sva i_sva (
  .CLK_50M            (CLK_50M),
  .rst_n              (rst_n),
  .sample_tick        (sample_tick),
  .audio_valid        (audio_valid),
  .word_req_pulse     (word_req.req),
  .word_rsp_valid     (word_rsp.valid),
  .flash_read         (flash_read),
  .flash_readdatavalid(flash_readdatavalid)
);

// File: rtl/ipod_player_top.sv
`timescale 1ns/1ps

module ipod_player_top #(
  parameter ipod_pkg::div_t  DIV_DEFAULT       = 24'd1136,
  parameter ipod_pkg::div_t  DIV_STEP          = 24'd100,
  parameter ipod_pkg::div_t  DIV_MIN           = 24'd200,
  parameter ipod_pkg::div_t  DIV_MAX           = 24'd5000,
  parameter int              KEY_REPEAT_CYCLES = 5_000_000,
  parameter ipod_pkg::addr_t ADDR_LAST         = 23'h7FFFF,
  parameter int              REFRESH_CYCLES    = 25_000_000
) (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic [2:0]            key_n,               // 0 up, 1 down, 2 rate reset
  input  ipod_pkg::ascii_t      kbd_ascii,
  input  logic                  kbd_valid,
  input  ipod_pkg::flash_word_t flash_readdata,
  input  logic                  flash_readdatavalid,
  output logic                  flash_read,
  output ipod_pkg::addr_t       flash_address,
  output ipod_pkg::sample_t     audio_sample,
  output logic                  audio_valid,
  output ipod_pkg::seg_t        hex0,
  output ipod_pkg::seg_t        hex1,
  output ipod_pkg::seg_t        hex2,
  output ipod_pkg::seg_t        hex3,
  output ipod_pkg::seg_t        hex4,
  output ipod_pkg::seg_t        hex5,
  output logic                  led_playing,
  output logic                  led_forward
);

  ipod_pkg::div_t      div_value;
  logic                sample_tick;
  ipod_pkg::word_req_s word_req;
  ipod_pkg::word_rsp_s word_rsp;
  logic                playing;
  logic                forward;

  // ==================================================
  // Rate path
  // ==================================================
  speed_control #(
    .DIV_DEFAULT      (DIV_DEFAULT),
    .DIV_STEP         (DIV_STEP),
    .DIV_MIN          (DIV_MIN),
    .DIV_MAX          (DIV_MAX),
    .KEY_REPEAT_CYCLES(KEY_REPEAT_CYCLES)
  ) i_speed_control (
    .CLK_50M  (CLK_50M),
    .rst_n    (rst_n),
    .key_n    (key_n),
    .div_value(div_value)
  );

  sample_tick_gen i_sample_tick_gen (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .div_value  (div_value),
    .sample_tick(sample_tick)
  );

  // ==================================================
  // Playback and flash
  // ==================================================
  playback_ctrl #(
    .ADDR_LAST(ADDR_LAST)
  ) i_playback_ctrl (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .kbd_ascii   (kbd_ascii),
    .kbd_valid   (kbd_valid),
    .sample_tick (sample_tick),
    .word_rsp    (word_rsp),
    .word_req    (word_req),
    .audio_sample(audio_sample),
    .audio_valid (audio_valid),
    .playing     (playing),
    .forward     (forward)
  );

  flash_reader i_flash_reader (
    .CLK_50M            (CLK_50M),
    .rst_n              (rst_n),
    .word_req           (word_req),
    .flash_readdata     (flash_readdata),
    .flash_readdatavalid(flash_readdatavalid),
    .word_rsp           (word_rsp),
    .flash_read         (flash_read),
    .flash_address      (flash_address)
  );

  hex_display #(
    .DIV_DEFAULT   (DIV_DEFAULT),
    .REFRESH_CYCLES(REFRESH_CYCLES)
  ) i_hex_display (
    .CLK_50M  (CLK_50M),
    .rst_n    (rst_n),
    .div_value(div_value),
    .hex0     (hex0),
    .hex1     (hex1),
    .hex2     (hex2),
    .hex3     (hex3),
    .hex4     (hex4),
    .hex5     (hex5)
  );

  assign led_playing = playing;
  assign led_forward = forward;

endmodule

// File: rtl/hex_display.sv
`timescale 1ns/1ps

module hex_display #(
  parameter ipod_pkg::div_t DIV_DEFAULT    = 24'd1136,
  parameter int             REFRESH_CYCLES = 25_000_000
) (
  input  logic           CLK_50M,
  input  logic           rst_n,
  input  ipod_pkg::div_t div_value,
  output ipod_pkg::seg_t hex0,
  output ipod_pkg::seg_t hex1,
  output ipod_pkg::seg_t hex2,
  output ipod_pkg::seg_t hex3,
  output ipod_pkg::seg_t hex4,
  output ipod_pkg::seg_t hex5
);

  localparam int REF_W = $clog2(REFRESH_CYCLES + 1);

  logic [REF_W-1:0] ref_cnt;
  logic             refresh;
  ipod_pkg::div_t   shown;  // Snapshot of the divisor

  // Active low patterns, gfedcba
  function automatic ipod_pkg::seg_t hex_to_seg(input logic [3:0] nib);
    case (nib)
      4'h0: hex_to_seg = 7'h40;
      4'h1: hex_to_seg = 7'h79;
      4'h2: hex_to_seg = 7'h24;
      4'h3: hex_to_seg = 7'h30;
      4'h4: hex_to_seg = 7'h19;
      4'h5: hex_to_seg = 7'h12;
      4'h6: hex_to_seg = 7'h02;
      4'h7: hex_to_seg = 7'h78;
      4'h8: hex_to_seg = 7'h00;
      4'h9: hex_to_seg = 7'h10;
      4'hA: hex_to_seg = 7'h08;
      4'hB: hex_to_seg = 7'h03;
      4'hC: hex_to_seg = 7'h46;
      4'hD: hex_to_seg = 7'h21;
      4'hE: hex_to_seg = 7'h06;
      default: hex_to_seg = 7'h0E;
    endcase
  endfunction

  assign refresh = (ref_cnt == REF_W'(REFRESH_CYCLES - 1));

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ref_cnt <= '0;
      shown   <= DIV_DEFAULT;
    end
    else
    begin
      ref_cnt <= refresh ? '0 : ref_cnt + 1'b1;
      if (refresh)
        shown <= div_value;
    end
  end

  // Digit 0 is the least significant nibble
  assign hex0 = hex_to_seg(shown[3:0]);
  assign hex1 = hex_to_seg(shown[7:4]);
  assign hex2 = hex_to_seg(shown[11:8]);
  assign hex3 = hex_to_seg(shown[15:12]);
  assign hex4 = hex_to_seg(shown[19:16]);
  assign hex5 = hex_to_seg(shown[23:20]);

endmodule

// File: playback/flash_reader.sv
`timescale 1ns/1ps

module flash_reader (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  ipod_pkg::word_req_s   word_req,
  input  ipod_pkg::flash_word_t flash_readdata,
  input  logic                  flash_readdatavalid,
  output ipod_pkg::word_rsp_s   word_rsp,
  output logic                  flash_read,
  output ipod_pkg::addr_t       flash_address
);

  ipod_pkg::fr_state_e   state;
  logic                  rsp_valid;
  ipod_pkg::flash_word_t rsp_data;

  assign word_rsp = '{valid: rsp_valid, data: rsp_data};

  // ==================================================
  // Read FSM
  // ==================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= ipod_pkg::FR_IDLE;
      flash_read <= 1'b0;
      rsp_valid  <= 1'b0;
    end
    else
    begin
      flash_read <= 1'b0;
      rsp_valid  <= 1'b0;
      case (state)
        ipod_pkg::FR_IDLE:
        begin
          if (flash_read)
            state <= ipod_pkg::FR_WAIT;  // Read pulse just went out
          else if (word_req.req)
            flash_read <= 1'b1;
        end
        ipod_pkg::FR_WAIT:
        begin
          if (flash_readdatavalid)
          begin
            rsp_valid <= 1'b1;
            state     <= ipod_pkg::FR_IDLE;
          end
        end
        default: state <= ipod_pkg::FR_IDLE;
      endcase
    end
  end

  // Address and returned word
  always_ff @(posedge CLK_50M)
  begin
    if (state == ipod_pkg::FR_IDLE && !flash_read && word_req.req)
      flash_address <= word_req.addr;
    if (state == ipod_pkg::FR_WAIT && flash_readdatavalid)
      rsp_data <= flash_readdata;
  end

endmodule

// File: playback/playback_ctrl.sv
`timescale 1ns/1ps

module playback_ctrl #(
  parameter ipod_pkg::addr_t ADDR_LAST = 23'h7FFFF
) (
  input  logic                CLK_50M,
  input  logic                rst_n,
  input  ipod_pkg::ascii_t    kbd_ascii,
  input  logic                kbd_valid,
  input  logic                sample_tick,
  input  ipod_pkg::word_rsp_s word_rsp,
  output ipod_pkg::word_req_s word_req,
  output ipod_pkg::sample_t   audio_sample,
  output logic                audio_valid,
  output logic                playing,
  output logic                forward
);

  ipod_pkg::addr_t       addr;       // Current word address
  ipod_pkg::addr_t       next_addr;
  ipod_pkg::flash_word_t word_buf;
  ipod_pkg::half_t       cur_half;
  logic                  word_fwd;   // Half order of the buffered word
  logic                  half_idx;   // 0 for the first half played
  logic                  have_word;
  logic                  outstanding;
  logic                  stale;      // Response to drop after restart
  logic                  req_pulse;
  logic                  need_req;
  logic                  emit;

  assign emit     = sample_tick & playing & have_word;
  assign need_req = playing & ~have_word & ~outstanding & ~req_pulse;

  assign next_addr = forward ? ((addr == ADDR_LAST) ? '0 : addr + 1'b1)
                             : ((addr == '0) ? ADDR_LAST : addr - 1'b1);

  // Forward plays lower first, backward upper first
  assign cur_half     = (half_idx ^ ~word_fwd) ? word_buf[31:16] : word_buf[15:0];
  assign audio_sample = cur_half[15:8];
  assign audio_valid  = emit;
  assign word_req     = '{req: req_pulse, addr: addr};

  always_ff @(posedge CLK_50M)
  begin
    if (word_rsp.valid)
      word_buf <= word_rsp.data;
  end

  // ==================================================
  // Control state
  // ==================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      playing     <= 1'b0;
      forward     <= 1'b1;
      addr        <= '0;
      word_fwd    <= 1'b1;
      half_idx    <= 1'b0;
      have_word   <= 1'b0;
      outstanding <= 1'b0;
      stale       <= 1'b0;
      req_pulse   <= 1'b0;
    end
    else
    begin
      req_pulse <= need_req;
      if (req_pulse)
        outstanding <= 1'b1;
      if (word_rsp.valid)
      begin
        outstanding <= 1'b0;
        stale       <= 1'b0;
        if (!stale)
        begin
          have_word <= 1'b1;
          half_idx  <= 1'b0;
          word_fwd  <= forward;
        end
      end
      if (emit)
      begin
        half_idx <= ~half_idx;
        if (half_idx)  // Word used up
        begin
          have_word <= 1'b0;
          addr      <= next_addr;
        end
      end
      if (kbd_valid)
      begin
        case (kbd_ascii)
          ipod_pkg::CMD_PLAY:    playing <= 1'b1;
          ipod_pkg::CMD_PAUSE:   playing <= 1'b0;
          ipod_pkg::CMD_FWD:     forward <= 1'b1;
          ipod_pkg::CMD_BACK:    forward <= 1'b0;
          ipod_pkg::CMD_RESTART:
          begin
            addr      <= forward ? '0 : ADDR_LAST;
            have_word <= 1'b0;
            half_idx  <= 1'b0;
            stale     <= (outstanding & ~word_rsp.valid) | req_pulse;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// File: rtl/sample_tick_gen.sv
`timescale 1ns/1ps

module sample_tick_gen (
  input  logic           CLK_50M,
  input  logic           rst_n,
  input  ipod_pkg::div_t div_value,
  output logic           sample_tick
);

  ipod_pkg::div_t cnt;

  // Down counter, reload picks up a new divisor
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      cnt <= '0;
    else if (sample_tick)
      cnt <= div_value - 1'b1;
    else
      cnt <= cnt - 1'b1;
  end

  // Terminal count
  assign sample_tick = (cnt == '0);

endmodule

// File: rtl/speed_control.sv
`timescale 1ns/1ps

module speed_control #(
  parameter ipod_pkg::div_t DIV_DEFAULT       = 24'd1136,
  parameter ipod_pkg::div_t DIV_STEP          = 24'd100,
  parameter ipod_pkg::div_t DIV_MIN           = 24'd200,
  parameter ipod_pkg::div_t DIV_MAX           = 24'd5000,
  parameter int             KEY_REPEAT_CYCLES = 5_000_000
) (
  input  logic           CLK_50M,
  input  logic           rst_n,
  input  logic [2:0]     key_n,
  output ipod_pkg::div_t div_value
);

  localparam int WIN_W = $clog2(KEY_REPEAT_CYCLES + 1);

  logic [2:0]       key_meta;
  logic [2:0]       key_sync;
  logic [WIN_W-1:0] win_cnt;
  logic             win_end;
  logic             up_held;
  logic             down_held;
  logic             rst_held;

  // ==================================================
  // Key synchronizer
  // ==================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      key_meta <= 3'b111;  // Released
      key_sync <= 3'b111;
    end
    else
    begin
      key_meta <= key_n;
      key_sync <= key_meta;
    end
  end

  assign up_held   = ~key_sync[0];
  assign down_held = ~key_sync[1];
  assign rst_held  = ~key_sync[2];

  // Repeat window, about ten steps per second
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      win_cnt <= '0;
    else if (win_end)
      win_cnt <= '0;
    else
      win_cnt <= win_cnt + 1'b1;
  end

  assign win_end = (win_cnt == WIN_W'(KEY_REPEAT_CYCLES - 1));

  // ==================================================
  // Divisor register
  // ==================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      div_value <= DIV_DEFAULT;
    else if (rst_held)
      div_value <= DIV_DEFAULT;  // Wins over up and down
    else if (win_end && up_held && !down_held)
    begin
      // Faster rate, smaller divisor
      if (div_value < DIV_MIN + DIV_STEP)
        div_value <= DIV_MIN;
      else
        div_value <= div_value - DIV_STEP;
    end
    else if (win_end && down_held && !up_held)
    begin
      if (div_value > DIV_MAX - DIV_STEP)
        div_value <= DIV_MAX;
      else
        div_value <= div_value + DIV_STEP;
    end
  end

endmodule

// File: common/ipod_pkg.sv
package ipod_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int ADDR_W  = 23;  // Flash word address
  localparam int WORD_W  = 32;
  localparam int HALF_W  = 16;
  localparam int SAMP_W  = 8;
  localparam int DIV_W   = 24;  // Six hex digits on the display
  localparam int SEG_W   = 7;
  localparam int ASCII_W = 8;

  // ==================================================
  // Vector types
  // ==================================================
  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [WORD_W-1:0]  flash_word_t;
  typedef logic [HALF_W-1:0]  half_t;       // One stored sample
  typedef logic [SAMP_W-1:0]  sample_t;     // Upper byte of a half
  typedef logic [DIV_W-1:0]   div_t;
  typedef logic [SEG_W-1:0]   seg_t;        // Active low, bit 0 is segment a
  typedef logic [ASCII_W-1:0] ascii_t;

  // Keyboard commands, upper case ASCII
  typedef enum ascii_t {
    CMD_PLAY    = 8'h45,  // 'E'
    CMD_PAUSE   = 8'h44,  // 'D'
    CMD_FWD     = 8'h46,  // 'F'
    CMD_BACK    = 8'h42,  // 'B'
    CMD_RESTART = 8'h52   // 'R'
  } kbd_cmd_e;

  // Flash reader FSM
  typedef enum logic {
    FR_IDLE = 1'b0,
    FR_WAIT = 1'b1
  } fr_state_e;

  // ==================================================
  // Word request and response
  // ==================================================
  typedef struct packed {
    logic  req;   // One cycle pulse
    addr_t addr;
  } word_req_s;

  typedef struct packed {
    logic        valid;  // One cycle pulse
    flash_word_t data;
  } word_rsp_s;

endpackage
